// ==== rtl/frontend_pkg.sv ====
// shared widths, types and constants of the fetch frontend, referenced by scoped name
`default_nettype none

package frontend_pkg;

  // -------------------------------------------------------------------
  // datapath widths
  // -------------------------------------------------------------------
  localparam int XLEN       = 32;
  localparam int InstrBytes = 4;

  typedef logic [XLEN-1:0] addr_t;
  typedef logic [XLEN-1:0] instr_t;
  typedef logic [XLEN-1:0] imm_t;

  // major opcodes of the control-flow instructions
  localparam logic [6:0] OpcodeBranch = 7'b1100011;
  localparam logic [6:0] OpcodeJal    = 7'b1101111;
  localparam logic [6:0] OpcodeJalr   = 7'b1100111;

  // -------------------------------------------------------------------
  // branch history table
  // -------------------------------------------------------------------
  localparam int BhtEntries = 16;
  localparam int BhtIdxW    = 4;

  typedef logic [BhtIdxW-1:0] bht_idx_t;
  // msb set means predict taken
  typedef logic [1:0] bht_ctr_t;

  localparam bht_ctr_t BhtCtrInitTaken    = 2'd2;
  localparam bht_ctr_t BhtCtrInitNotTaken = 2'd1;
  localparam bht_ctr_t BhtCtrMax          = 2'd3;
  localparam bht_ctr_t BhtCtrMin          = 2'd0;

  // -------------------------------------------------------------------
  // fetch queue
  // -------------------------------------------------------------------
  localparam int QueueDepth = 4;
  localparam int QueuePtrW  = $clog2(QueueDepth);
  localparam int QueueCntW  = $clog2(QueueDepth + 1);

  typedef logic [QueuePtrW-1:0] qptr_t;
  typedef logic [QueueCntW-1:0] qcnt_t;

  // control-flow kind of a scanned instruction
  typedef enum logic [1:0] {
    CF_NONE,
    CF_BRANCH,
    CF_JAL,
    CF_JALR
  } cf_e;

  // four-phase memory handshake
  typedef enum logic [1:0] {
    FS_IDLE,
    FS_WAIT_ACK,
    FS_WAIT_RELEASE
  } fetch_state_e;

endpackage

`default_nettype wire

// ==== rtl/instr_scan.sv ====
// combinational scan of one fetched word, gives its control-flow kind and immediate
`default_nettype none
`timescale 1ns/1ns

module instr_scan (
  input  frontend_pkg::instr_t instr_i,
  output frontend_pkg::cf_e    cf_o,
  output frontend_pkg::imm_t   imm_o
);

  logic [6:0]         opcode;
  frontend_pkg::imm_t b_imm;
  frontend_pkg::imm_t j_imm;

  assign opcode = instr_i[6:0];

  // B-type: imm[12|10:5|4:1|11], lsb always zero
  assign b_imm = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};

  // J-type: imm[20|10:1|11|19:12]
  assign j_imm = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb begin
    cf_o  = frontend_pkg::CF_NONE;
    imm_o = '0;
    case (opcode)
      frontend_pkg::OpcodeBranch: begin
        cf_o  = frontend_pkg::CF_BRANCH;
        imm_o = b_imm;
      end
      frontend_pkg::OpcodeJal: begin
        cf_o  = frontend_pkg::CF_JAL;
        imm_o = j_imm;
      end
      // target comes from a register, nothing to predict here
      frontend_pkg::OpcodeJalr: begin
        cf_o = frontend_pkg::CF_JALR;
      end
      default: begin
        cf_o  = frontend_pkg::CF_NONE;
        imm_o = '0;
      end
    endcase
  end

  // an unknown word still has to decode to one of the four kinds
  always_comb begin
    a_cf_legal: assert final (cf_o inside {frontend_pkg::CF_NONE, frontend_pkg::CF_BRANCH,
                                           frontend_pkg::CF_JAL, frontend_pkg::CF_JALR})
      else $error("instr_scan: illegal control-flow kind %0d", cf_o);
  end

endmodule

`default_nettype wire

// ==== rtl/branch_history_table.sv ====
// table of 2-bit branch counters, read at the fetch pc and trained by resolved branches
`default_nettype none
`timescale 1ns/1ns

module branch_history_table (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  frontend_pkg::addr_t lookup_pc_i,
  output logic                pred_valid_o,
  output logic                pred_taken_o,
  input  logic                resolve_valid_i,
  input  logic                resolve_is_branch_i,
  input  logic                resolve_taken_i,
  input  frontend_pkg::addr_t resolve_pc_i
);

  logic [frontend_pkg::BhtEntries-1:0] valid_q;
  frontend_pkg::bht_ctr_t              ctr_q [frontend_pkg::BhtEntries];

  frontend_pkg::bht_idx_t rd_idx;
  frontend_pkg::bht_idx_t upd_idx;
  frontend_pkg::bht_ctr_t upd_ctr;
  frontend_pkg::bht_ctr_t ctr_next;
  logic                   upd_en;
  logic                   upd_valid;

  // word-aligned pc, so the index starts at bit 2
  assign rd_idx  = lookup_pc_i[frontend_pkg::BhtIdxW+1:2];
  assign upd_idx = resolve_pc_i[frontend_pkg::BhtIdxW+1:2];

  assign pred_valid_o = valid_q[rd_idx];
  assign pred_taken_o = valid_q[rd_idx] & ctr_q[rd_idx][1];

  assign upd_en    = resolve_valid_i & resolve_is_branch_i;
  assign upd_valid = valid_q[upd_idx];
  assign upd_ctr   = ctr_q[upd_idx];

  // -------------------------------------------------------------------
  // counter update
  // -------------------------------------------------------------------
  always_comb begin
    if (!upd_valid) begin
      // first training starts weakly biased toward the outcome
      ctr_next = resolve_taken_i ? frontend_pkg::BhtCtrInitTaken
                                 : frontend_pkg::BhtCtrInitNotTaken;
    end else if (resolve_taken_i) begin
      ctr_next = (upd_ctr == frontend_pkg::BhtCtrMax) ? upd_ctr : upd_ctr + 2'd1;
    end else begin
      ctr_next = (upd_ctr == frontend_pkg::BhtCtrMin) ? upd_ctr : upd_ctr - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (upd_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (upd_en) begin
      ctr_q[upd_idx] <= ctr_next;
    end
  end

  // a taken update never lowers the counter, a not-taken one never raises it
  a_sat_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_en && upd_valid && resolve_taken_i
    |=> ctr_q[$past(upd_idx)] >= $past(upd_ctr))
    else $error("branch_history_table: counter wrapped above 3");

  a_sat_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    upd_en && upd_valid && !resolve_taken_i
    |=> ctr_q[$past(upd_idx)] <= $past(upd_ctr))
    else $error("branch_history_table: counter wrapped below 0");

endmodule

`default_nettype wire

// ==== rtl/fetch_ctrl.sv ====
// fetch pc, next-pc prediction, back-end redirects and the four-phase memory handshake
`default_nettype none
`timescale 1ns/1ns

module fetch_ctrl (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  frontend_pkg::addr_t  boot_addr_i,
  input  logic                 flush_i,
  input  frontend_pkg::addr_t  flush_pc_i,
  input  logic                 resolve_valid_i,
  input  logic                 resolve_mispredict_i,
  input  frontend_pkg::addr_t  resolve_target_i,
  output logic                 imem_req_o,
  output frontend_pkg::addr_t  imem_addr_o,
  input  logic                 imem_ack_i,
  input  frontend_pkg::instr_t imem_rdata_i,
  input  frontend_pkg::cf_e    cf_i,
  input  frontend_pkg::imm_t   imm_i,
  input  logic                 bht_valid_i,
  input  logic                 bht_taken_i,
  input  logic                 queue_has_room_i,
  output logic                 redirect_o,
  output logic                 push_o,
  output logic                 push_taken_o,
  output frontend_pkg::addr_t  pc_o
);

  frontend_pkg::fetch_state_e state_q, state_d;
  frontend_pkg::addr_t        pc_q, pc_d;
  frontend_pkg::addr_t        addr_q;
  frontend_pkg::addr_t        pred_pc;
  logic                       discard_q, discard_d;
  logic                       mispredict;
  logic                       take_in;
  logic                       launch;
  logic                       pred_taken;

  assign mispredict = resolve_valid_i & resolve_mispredict_i;
  assign redirect_o = flush_i | mispredict;

  // word accepted on this edge, unless it belongs to a stale request
  assign take_in = (state_q == frontend_pkg::FS_WAIT_ACK) & imem_ack_i & ~discard_q;
  assign launch  = (state_q == frontend_pkg::FS_IDLE) & (state_d == frontend_pkg::FS_WAIT_ACK);

  // -------------------------------------------------------------------
  // next-pc prediction
  // -------------------------------------------------------------------
  always_comb begin
    case (cf_i)
      frontend_pkg::CF_JAL:    pred_taken = 1'b1;
      // no table entry yet: backward taken, forward not taken
      frontend_pkg::CF_BRANCH: pred_taken = bht_valid_i ? bht_taken_i
                                                        : imm_i[frontend_pkg::XLEN-1];
      default:                 pred_taken = 1'b0;
    endcase
  end

  assign pred_pc = pred_taken ? pc_q + imm_i
                              : pc_q + frontend_pkg::addr_t'(frontend_pkg::InstrBytes);

  always_comb begin
    if (flush_i) begin
      pc_d = flush_pc_i;
    end else if (mispredict) begin
      pc_d = resolve_target_i;
    end else if (take_in) begin
      pc_d = pred_pc;
    end else begin
      pc_d = pc_q;
    end
  end

  // -------------------------------------------------------------------
  // memory handshake
  // -------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    discard_d = 1'b0;
    case (state_q)
      frontend_pkg::FS_IDLE: begin
        if (queue_has_room_i) begin
          state_d = frontend_pkg::FS_WAIT_ACK;
        end
      end
      frontend_pkg::FS_WAIT_ACK: begin
        if (imem_ack_i) begin
          state_d = frontend_pkg::FS_WAIT_RELEASE;
        end else begin
          // response still in flight, drop it when it arrives
          discard_d = discard_q | redirect_o;
        end
      end
      frontend_pkg::FS_WAIT_RELEASE: begin
        if (!imem_ack_i) begin
          state_d = frontend_pkg::FS_IDLE;
        end
      end
      default: state_d = frontend_pkg::FS_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= frontend_pkg::FS_IDLE;
      discard_q <= 1'b0;
      pc_q      <= boot_addr_i;
    end else begin
      state_q   <= state_d;
      discard_q <= discard_d;
      pc_q      <= pc_d;
    end
  end

  // request address, held for the whole handshake even across a redirect
  always_ff @(posedge clk_i) begin
    if (launch) begin
      addr_q <= pc_d;
    end
  end

  assign imem_req_o   = (state_q == frontend_pkg::FS_WAIT_ACK);
  assign imem_addr_o  = addr_q;
  assign push_o       = take_in & ~redirect_o;
  assign push_taken_o = pred_taken;
  assign pc_o         = pc_q;

  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o && !imem_ack_i |=> imem_req_o)
    else $error("fetch_ctrl: req dropped before ack");

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o && !imem_ack_i |=> $stable(imem_addr_o))
    else $error("fetch_ctrl: address changed while req was high");

  a_rdata_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    imem_req_o && imem_ack_i |-> !$isunknown(imem_rdata_i))
    else $error("fetch_ctrl: memory returned unknown data with ack");

endmodule

`default_nettype wire

// ==== rtl/fetch_queue.sv ====
// small FIFO of fetched entries toward decode, emptied by a redirect
`default_nettype none
`timescale 1ns/1ns

module fetch_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 flush_i,
  input  logic                 push_i,
  input  frontend_pkg::addr_t  push_pc_i,
  input  frontend_pkg::instr_t push_instr_i,
  input  logic                 push_taken_i,
  output logic                 has_room_o,
  output logic                 fetch_valid_o,
  output frontend_pkg::addr_t  fetch_pc_o,
  output frontend_pkg::instr_t fetch_instr_o,
  output logic                 fetch_taken_o,
  input  logic                 fetch_ready_i
);

  frontend_pkg::addr_t  pc_mem    [frontend_pkg::QueueDepth];
  frontend_pkg::instr_t instr_mem [frontend_pkg::QueueDepth];
  logic                 taken_mem [frontend_pkg::QueueDepth];

  frontend_pkg::qptr_t wr_ptr_q;
  frontend_pkg::qptr_t rd_ptr_q;
  frontend_pkg::qcnt_t count_q;
  logic                pop;

  assign has_room_o    = count_q < frontend_pkg::qcnt_t'(frontend_pkg::QueueDepth);
  assign fetch_valid_o = (count_q != '0);
  assign pop           = fetch_valid_o & fetch_ready_i;

  // head entry straight from storage
  assign fetch_pc_o    = pc_mem[rd_ptr_q];
  assign fetch_instr_o = instr_mem[rd_ptr_q];
  assign fetch_taken_o = taken_mem[rd_ptr_q];

  // -------------------------------------------------------------------
  // pointers and fill level
  // -------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + frontend_pkg::qptr_t'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + frontend_pkg::qptr_t'(1);
      end
      count_q <= count_q + frontend_pkg::qcnt_t'(push_i) - frontend_pkg::qcnt_t'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      pc_mem[wr_ptr_q]    <= push_pc_i;
      instr_mem[wr_ptr_q] <= push_instr_i;
      taken_mem[wr_ptr_q] <= push_taken_i;
    end
  end

  // fetch_ctrl must hold req low while the queue is full
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> has_room_o)
    else $error("fetch_queue: push into a full queue");

endmodule

`default_nettype wire

// ==== rtl/fetch_frontend.sv ====
// fetch frontend top, ties fetch control, scan, history table and queue to memory and decode
`default_nettype none
`timescale 1ns/1ns

module fetch_frontend (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  frontend_pkg::addr_t  boot_addr_i,
  // redirect from commit
  input  logic                 flush_i,
  input  frontend_pkg::addr_t  flush_pc_i,
  // branch resolution from execute
  input  logic                 resolve_valid_i,
  input  logic                 resolve_mispredict_i,
  input  logic                 resolve_is_branch_i,
  input  logic                 resolve_taken_i,
  input  frontend_pkg::addr_t  resolve_pc_i,
  input  frontend_pkg::addr_t  resolve_target_i,
  // instruction memory
  output logic                 imem_req_o,
  output frontend_pkg::addr_t  imem_addr_o,
  input  logic                 imem_ack_i,
  input  frontend_pkg::instr_t imem_rdata_i,
  // decode
  output logic                 fetch_valid_o,
  output frontend_pkg::addr_t  fetch_pc_o,
  output frontend_pkg::instr_t fetch_instr_o,
  output logic                 fetch_taken_o,
  input  logic                 fetch_ready_i
);

  frontend_pkg::cf_e   scan_cf;
  frontend_pkg::imm_t  scan_imm;
  frontend_pkg::addr_t fetch_pc;
  logic                bht_valid;
  logic                bht_taken;
  logic                queue_has_room;
  logic                redirect;
  logic                push;
  logic                push_taken;

  instr_scan i_instr_scan (
    .instr_i (imem_rdata_i),
    .cf_o    (scan_cf),
    .imm_o   (scan_imm)
  );

  branch_history_table i_bht (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .lookup_pc_i         (fetch_pc),
    .pred_valid_o        (bht_valid),
    .pred_taken_o        (bht_taken),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_is_branch_i (resolve_is_branch_i),
    .resolve_taken_i     (resolve_taken_i),
    .resolve_pc_i        (resolve_pc_i)
  );

  fetch_ctrl i_fetch_ctrl (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .flush_i              (flush_i),
    .flush_pc_i           (flush_pc_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_target_i     (resolve_target_i),
    .imem_req_o           (imem_req_o),
    .imem_addr_o          (imem_addr_o),
    .imem_ack_i           (imem_ack_i),
    .imem_rdata_i         (imem_rdata_i),
    .cf_i                 (scan_cf),
    .imm_i                (scan_imm),
    .bht_valid_i          (bht_valid),
    .bht_taken_i          (bht_taken),
    .queue_has_room_i     (queue_has_room),
    .redirect_o           (redirect),
    .push_o               (push),
    .push_taken_o         (push_taken),
    .pc_o                 (fetch_pc)
  );

  // a redirect empties the queue in the same cycle
  fetch_queue i_fetch_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (redirect),
    .push_i        (push),
    .push_pc_i     (fetch_pc),
    .push_instr_i  (imem_rdata_i),
    .push_taken_i  (push_taken),
    .has_room_o    (queue_has_room),
    .fetch_valid_o (fetch_valid_o),
    .fetch_pc_o    (fetch_pc_o),
    .fetch_instr_o (fetch_instr_o),
    .fetch_taken_o (fetch_taken_o),
    .fetch_ready_i (fetch_ready_i)
  );

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
// testbench clock and reset source for the fetch frontend, 100 ns period, reset low at start
`default_nettype none
`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HalfPeriod  = 50;
  localparam int ResetCycles = 5;
  // same offset after the edge as the other testbench drivers
  localparam int ReleaseDly  = 10;

  initial begin
    clk_o = 1'b0;
    forever #HalfPeriod clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #ReleaseDly rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verification/tb_fetch_frontend.sv ====
// testbench top for the fetch frontend, runs memory responder, reference model and checks
`default_nettype none
`timescale 1ns/1ns

module tb_fetch_frontend;

  localparam int                  DrvDelay = 10;
  localparam logic [15:0]         LfsrSeed = 16'd3680;
  localparam frontend_pkg::addr_t BootAddr = 32'h0000_1000;
  localparam int                  ReqLimit = 600;

  logic                 clk_i;
  logic                 rst_ni;
  frontend_pkg::addr_t  boot_addr_i;
  logic                 flush_i;
  frontend_pkg::addr_t  flush_pc_i;
  logic                 resolve_valid_i;
  logic                 resolve_mispredict_i;
  logic                 resolve_is_branch_i;
  logic                 resolve_taken_i;
  frontend_pkg::addr_t  resolve_pc_i;
  frontend_pkg::addr_t  resolve_target_i;
  logic                 imem_req_o;
  frontend_pkg::addr_t  imem_addr_o;
  logic                 imem_ack_i;
  frontend_pkg::instr_t imem_rdata_i;
  logic                 fetch_valid_o;
  frontend_pkg::addr_t  fetch_pc_o;
  frontend_pkg::instr_t fetch_instr_o;
  logic                 fetch_taken_o;
  logic                 fetch_ready_i;

  // reference state, updated by the comparing process
  frontend_pkg::addr_t    exp_pc = BootAddr;
  logic                   mdl_valid [frontend_pkg::BhtEntries] = '{default: 1'b0};
  frontend_pkg::bht_ctr_t mdl_ctr   [frontend_pkg::BhtEntries];
  int                     consumed = 0;
  int                     err_cnt = 0;
  logic [15:0]            mem_lfsr = LfsrSeed;
  logic [15:0]            ready_lfsr = LfsrSeed;

  tb_clk_gen i_clk_gen (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  fetch_frontend DUT (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .flush_i              (flush_i),
    .flush_pc_i           (flush_pc_i),
    .resolve_valid_i      (resolve_valid_i),
    .resolve_mispredict_i (resolve_mispredict_i),
    .resolve_is_branch_i  (resolve_is_branch_i),
    .resolve_taken_i      (resolve_taken_i),
    .resolve_pc_i         (resolve_pc_i),
    .resolve_target_i     (resolve_target_i),
    .imem_req_o           (imem_req_o),
    .imem_addr_o          (imem_addr_o),
    .imem_ack_i           (imem_ack_i),
    .imem_rdata_i         (imem_rdata_i),
    .fetch_valid_o        (fetch_valid_o),
    .fetch_pc_o           (fetch_pc_o),
    .fetch_instr_o        (fetch_instr_o),
    .fetch_taken_o        (fetch_taken_o),
    .fetch_ready_i        (fetch_ready_i)
  );

  // ---------------------------------------------------------------------
  // program image and encoders
  // ---------------------------------------------------------------------
  function automatic frontend_pkg::instr_t jal_word(input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], 5'd1, frontend_pkg::OpcodeJal};
  endfunction

  function automatic frontend_pkg::instr_t branch_word(input logic [2:0] f3,
                                                       input logic [12:0] off);
    return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], frontend_pkg::OpcodeBranch};
  endfunction

  function automatic frontend_pkg::instr_t imem_word(input frontend_pkg::addr_t addr);
    case (addr)
      BootAddr + 32'h08: return jal_word(21'd16);
      BootAddr + 32'h1c: return branch_word(3'b000, 13'd12);
      BootAddr + 32'h24: return {12'd0, 5'd1, 3'b000, 5'd0, frontend_pkg::OpcodeJalr};
      BootAddr + 32'h2c: return branch_word(3'b001, 13'(-20));
      // everything else is an addi whose fields hash the full address
      default: return {addr[31:7] ^ addr[26:2] ^ {23'd0, addr[1:0]}, 7'b0010011};
    endcase
  endfunction

  // ---------------------------------------------------------------------
  // reference model
  // ---------------------------------------------------------------------
  function automatic void predict_entry(input frontend_pkg::addr_t pc,
                                        output frontend_pkg::instr_t instr,
                                        output logic taken,
                                        output frontend_pkg::addr_t next_pc);
    frontend_pkg::imm_t imm;
    int                 idx;
    instr = imem_word(pc);
    idx   = pc[5:2];
    imm   = '0;
    taken = 1'b0;
    if (instr[6:0] == frontend_pkg::OpcodeJal) begin
      imm   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      taken = 1'b1;
    end else if (instr[6:0] == frontend_pkg::OpcodeBranch) begin
      imm   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      // static rule when untrained: backward taken
      taken = mdl_valid[idx] ? mdl_ctr[idx][1] : imm[31];
    end
    next_pc = taken ? pc + imm : pc + 32'd4;
  endfunction

  function automatic void model_train(input frontend_pkg::addr_t pc, input logic taken);
    int idx;
    idx = pc[5:2];
    if (!mdl_valid[idx]) begin
      mdl_valid[idx] = 1'b1;
      mdl_ctr[idx]   = taken ? frontend_pkg::BhtCtrInitTaken : frontend_pkg::BhtCtrInitNotTaken;
    end else if (taken && mdl_ctr[idx] != 2'd3) begin
      mdl_ctr[idx] = mdl_ctr[idx] + 2'd1;
    end else if (!taken && mdl_ctr[idx] != 2'd0) begin
      mdl_ctr[idx] = mdl_ctr[idx] - 2'd1;
    end
  endfunction

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_bits(inout logic [15:0] s, input int n, output int val);
    int i;
    val = 0;
    for (i = 0; i < n; i++) begin
      s   = lfsr_step(s);
      val = (val << 1) | int'(s[0]);
    end
  endtask

  // ---------------------------------------------------------------------
  // error handling and compares
  // ---------------------------------------------------------------------
  task automatic stop_on_error(input string what);
    err_cnt++;
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic addr_check(input string name, input frontend_pkg::addr_t got,
                            input frontend_pkg::addr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                              $time, name, got, exp));
    end
  endtask

  task automatic instr_check(input string name, input frontend_pkg::instr_t got,
                             input frontend_pkg::instr_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t ns: %s = 0x%08h, expected 0x%08h",
                              $time, name, got, exp));
    end
  endtask

  task automatic bit_check(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t ns: %s = %b, expected %b", $time, name, got, exp));
    end
  endtask

  // ---------------------------------------------------------------------
  // timing helpers
  // ---------------------------------------------------------------------
  task automatic next_cycle();
    @(posedge clk_i);
    #DrvDelay;
  endtask

  task automatic wait_req_level(input logic level);
    int n;
    n = 0;
    next_cycle();
    while (imem_req_o !== level) begin
      if (n >= ReqLimit) begin
        stop_on_error($sformatf("timeout: imem_req_o never went to %b", level));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic wait_consumed(input int count);
    int target;
    int limit;
    int n;
    target = consumed + count;
    limit  = 20 * count + 100;
    n      = 0;
    while (consumed < target) begin
      if (n >= limit) begin
        stop_on_error($sformatf("timeout: only %0d of %0d entries reached decode",
                                consumed, target));
      end
      next_cycle();
      n++;
    end
  endtask

  task automatic resolve_pulse(input logic mispredict, input logic is_branch,
                               input frontend_pkg::addr_t pc, input logic taken,
                               input frontend_pkg::addr_t target);
    resolve_valid_i      = 1'b1;
    resolve_mispredict_i = mispredict;
    resolve_is_branch_i  = is_branch;
    resolve_pc_i         = pc;
    resolve_taken_i      = taken;
    resolve_target_i     = target;
    next_cycle();
    resolve_valid_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_is_branch_i  = 1'b0;
  endtask

  task automatic train_branch(input frontend_pkg::addr_t pc, input logic taken);
    resolve_pulse(1'b0, 1'b1, pc, taken, '0);
  endtask

  task automatic flush_to(input frontend_pkg::addr_t pc);
    flush_i    = 1'b1;
    flush_pc_i = pc;
    next_cycle();
    flush_i    = 1'b0;
  endtask

  task automatic restart_and_check(input frontend_pkg::addr_t pc, input int count);
    flush_to(pc);
    fetch_ready_i = 1'b1;
    wait_consumed(count);
  endtask

  // ---------------------------------------------------------------------
  // memory responder, four-phase with 0 to 3 cycles of ack delay
  // ---------------------------------------------------------------------
  initial begin : mem_responder
    int delay;
    imem_ack_i   = 1'b0;
    imem_rdata_i = '0;
    forever begin
      wait_req_level(1'b1);
      draw_bits(mem_lfsr, 2, delay);
      repeat (delay) next_cycle();
      imem_rdata_i = imem_word(imem_addr_o);
      imem_ack_i   = 1'b1;
      wait_req_level(1'b0);
      imem_ack_i   = 1'b0;
    end
  end

  // outputs sampled at the falling edge, inputs are settled by then
  always @(negedge clk_i) begin : compare_entries
    frontend_pkg::instr_t exp_instr;
    frontend_pkg::addr_t  exp_next;
    logic                 exp_taken;
    logic                 redirect;
    if (rst_ni) begin
      redirect = flush_i | (resolve_valid_i & resolve_mispredict_i);
      // a redirect on the same edge empties the queue instead of popping
      if (fetch_valid_o && fetch_ready_i && !redirect) begin
        predict_entry(exp_pc, exp_instr, exp_taken, exp_next);
        addr_check("fetch_pc_o", fetch_pc_o, exp_pc);
        instr_check("fetch_instr_o", fetch_instr_o, exp_instr);
        bit_check("fetch_taken_o", fetch_taken_o, exp_taken);
        exp_pc = exp_next;
        consumed++;
      end
      if (resolve_valid_i && resolve_is_branch_i) begin
        model_train(resolve_pc_i, resolve_taken_i);
      end
      if (flush_i) begin
        exp_pc = flush_pc_i;
      end else if (resolve_valid_i && resolve_mispredict_i) begin
        exp_pc = resolve_target_i;
      end
    end
  end

  // ---------------------------------------------------------------------
  // stimulus
  // ---------------------------------------------------------------------
  initial begin : stimulus
    int n;
    int bits;
    int len;
    boot_addr_i          = BootAddr;
    flush_i              = 1'b0;
    flush_pc_i           = '0;
    resolve_valid_i      = 1'b0;
    resolve_mispredict_i = 1'b0;
    resolve_is_branch_i  = 1'b0;
    resolve_taken_i      = 1'b0;
    resolve_pc_i         = '0;
    resolve_target_i     = '0;
    fetch_ready_i        = 1'b0;

    // quiet outputs through reset and one cycle beyond
    n = 0;
    do begin
      @(negedge clk_i);
      bit_check("imem_req_o", imem_req_o, 1'b0);
      bit_check("fetch_valid_o", fetch_valid_o, 1'b0);
      n++;
      if (n > 20) begin
        stop_on_error("reset was never released");
      end
    end while (!rst_ni);
    next_cycle();
    bit_check("imem_req_o", imem_req_o, 1'b1);

    // boot, jal, jalr and static branch rule on an empty table
    fetch_ready_i = 1'b1;
    wait_consumed(24);

    // forward branch trained taken once
    fetch_ready_i = 1'b0;
    train_branch(BootAddr + 32'h1c, 1'b1);
    restart_and_check(BootAddr + 32'h18, 16);

    // down to zero, saturate, one step up, backward branch trained not taken
    fetch_ready_i = 1'b0;
    train_branch(BootAddr + 32'h1c, 1'b0);
    train_branch(BootAddr + 32'h1c, 1'b0);
    train_branch(BootAddr + 32'h1c, 1'b0);
    train_branch(BootAddr + 32'h1c, 1'b1);
    train_branch(BootAddr + 32'h2c, 1'b0);
    restart_and_check(BootAddr + 32'h18, 12);

    // up to three, saturate, then one step down
    fetch_ready_i = 1'b0;
    repeat (4) train_branch(BootAddr + 32'h1c, 1'b1);
    train_branch(BootAddr + 32'h1c, 1'b0);
    train_branch(BootAddr + 32'h2c, 1'b1);
    restart_and_check(BootAddr, 16);

    // redirects with a request in flight
    wait_req_level(1'b1);
    flush_to(BootAddr);
    wait_consumed(6);
    wait_req_level(1'b1);
    resolve_pulse(1'b1, 1'b0, BootAddr + 32'h24, 1'b1, BootAddr + 32'h40);
    wait_consumed(6);

    // flush and mispredict together, flush_pc_i wins
    flush_i    = 1'b1;
    flush_pc_i = BootAddr + 32'h18;
    resolve_pulse(1'b1, 1'b0, BootAddr + 32'h24, 1'b1, 32'h0000_2000);
    flush_i    = 1'b0;
    wait_consumed(6);

    // mispredicted branch also trains the table
    wait_req_level(1'b1);
    resolve_pulse(1'b1, 1'b1, BootAddr + 32'h2c, 1'b0, BootAddr + 32'h30);
    wait_consumed(8);

    // let the queue fill, then drop its contents
    fetch_ready_i = 1'b0;
    repeat (16) next_cycle();
    restart_and_check(BootAddr, 8);

    // random back-pressure on the decode side
    repeat (40) begin
      draw_bits(ready_lfsr, 1, bits);
      draw_bits(ready_lfsr, 3, len);
      fetch_ready_i = bits[0];
      repeat (len + 1) next_cycle();
    end
    fetch_ready_i = 1'b1;
    wait_consumed(8);

    $display("checked %0d entries at decode", consumed);
    if (err_cnt == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/frontend_pkg.sv
rtl/instr_scan.sv
rtl/branch_history_table.sv
rtl/fetch_ctrl.sv
rtl/fetch_queue.sv
rtl/fetch_frontend.sv
verification/tb_clk_gen.sv
verification/tb_fetch_frontend.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - files:
      - rtl/frontend_pkg.sv
      - rtl/instr_scan.sv
      - rtl/branch_history_table.sv
      - rtl/fetch_ctrl.sv
      - rtl/fetch_queue.sv
      - rtl/fetch_frontend.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/tb_fetch_frontend.sv
